// ==== pkt_apb_regs.sv ====
`default_nettype none
`timescale 1ns/1ns

module pkt_apb_regs (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [pkt_move_pkg::APB_ADDR_W-1:0] paddr,
    input  pkt_move_pkg::word_t                 pwdata,
    output pkt_move_pkg::word_t                 prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  pkt_move_pkg::ctrl_state_t           state,
    input  logic                                done,
    output logic                                start,
    output pkt_move_pkg::xfer_cfg_t             cfg
);
    import pkt_move_pkg::*;

    logic  access;
    logic  wr_access;
    logic  addr_ok;
    logic  busy;
    logic  start_req;
    logic  start_err;
    word_t count;

    assign access    = psel && penable;
    assign wr_access = access && pwrite;

    // a pending start pulse counts as busy so it cannot be doubled
    assign busy = (state != IDLE) || start;

    always_comb begin
        case (paddr)
            REG_SRC, REG_DST, REG_LEN, REG_CTRL, REG_COUNT: addr_ok = 1'b1;
            default: addr_ok = 1'b0;
        endcase
    end

    assign start_req = wr_access && (paddr == REG_CTRL) && pwdata[CTRL_START_BIT];
    assign start_err = start_req && busy;

    assign pready  = 1'b1;
    assign pslverr = access && (!addr_ok || start_err);

    // config only changes while idle, so the engines see it stable
    always_ff @(posedge clk) begin
        if (!reset) begin
            cfg <= '0;
        end
        else if (wr_access && !busy) begin
            case (paddr)
                REG_SRC: cfg.src <= addr_t'(pwdata);
                REG_DST: cfg.dst <= addr_t'(pwdata);
                REG_LEN: cfg.len <= len_t'(pwdata);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            start <= 1'b0;
            count <= '0;
        end
        else begin
            start <= start_req && !busy;
            if (done) begin
                count <= count + 1'b1;
            end
        end
    end

    always_comb begin
        case (paddr)
            REG_SRC:   prdata = word_t'(cfg.src);
            REG_DST:   prdata = word_t'(cfg.dst);
            REG_LEN:   prdata = word_t'(cfg.len);
            REG_CTRL:  prdata = word_t'({state, busy});
            REG_COUNT: prdata = count;
            default:   prdata = '0;
        endcase
    end

    // the control FSM must have returned to idle before a new start
    start_only_idle: assert property (@(posedge clk) disable iff (!reset)
        start |-> state == IDLE);

endmodule : pkt_apb_regs

`default_nettype wire

// ==== pkt_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ns

module pkt_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  logic                      rd_done,
    input  logic                      wr_done,
    output logic                      rd_go,
    output logic                      wr_go,
    output logic                      done,
    output pkt_move_pkg::ctrl_state_t state
);
    import pkt_move_pkg::*;

    ctrl_state_t state_next;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= IDLE;
        end
        else begin
            state <= state_next;
        end
    end

    // ******************************
    // next state
    // ******************************
    always_comb begin
        case (state)
            IDLE: begin
                state_next = start ? RUN : IDLE;
            end
            RUN: begin
                if (rd_done && wr_done) begin
                    state_next = DONE;
                end
                else if (rd_done) begin
                    state_next = RD_DONE;
                end
                else begin
                    state_next = RUN;
                end
            end
            RD_DONE: begin
                state_next = wr_done ? DONE : RD_DONE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    assign rd_go = (state == RUN);
    assign wr_go = (state == RUN) || (state == RD_DONE);
    assign done  = (state == DONE);

    // the writer can only move words the reader has already fetched
    wr_after_rd: assert property (@(posedge clk) disable iff (!reset)
        wr_done |-> rd_done);

endmodule : pkt_ctrl

`default_nettype wire

// ==== pkt_fifo.sv ====
`default_nettype none
`timescale 1ns/1ns

module pkt_fifo (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                push,
    input  pkt_move_pkg::word_t                 push_data,
    input  logic                                pop,
    output pkt_move_pkg::word_t                 front,
    output logic                                empty,
    output logic [pkt_move_pkg::FIFO_CNT_W-1:0] count
);
    import pkt_move_pkg::*;

    word_t                 mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic                  full;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign front = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == FIFO_CNT_W'(FIFO_DEPTH));

    // the read engine reserves space for its reads before issuing them
    no_overflow: assert property (@(posedge clk) disable iff (!reset) push |-> !full);
    no_underflow: assert property (@(posedge clk) disable iff (!reset) pop |-> !empty);

endmodule : pkt_fifo

`default_nettype wire

// ==== pkt_move.f ====
pkt_move_pkg.sv
pkt_apb_regs.sv
pkt_ctrl.sv
pkt_rd_engine.sv
pkt_fifo.sv
pkt_wr_engine.sv
pkt_move_top.sv
pkt_move_tb.sv

// ==== pkt_move_pkg.sv ====
`default_nettype none

package pkt_move_pkg;

    // ******************************
    // basic widths
    // ******************************
    typedef logic [15:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  len_t;

    // configuration latched when a transfer starts
    typedef struct packed {
        addr_t src;
        addr_t dst;
        len_t  len;
    } xfer_cfg_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        word_t data;
    } mem_wr_req_t;

    typedef enum logic [1:0] { IDLE, RUN, RD_DONE, DONE } ctrl_state_t;

    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_CNT_W = 3;
    localparam int FIFO_PTR_W = 2;

    // ******************************
    // APB register map
    // ******************************
    localparam int APB_ADDR_W = 5;
    localparam logic [APB_ADDR_W-1:0] REG_SRC   = 5'h00;
    localparam logic [APB_ADDR_W-1:0] REG_DST   = 5'h04;
    localparam logic [APB_ADDR_W-1:0] REG_LEN   = 5'h08;
    localparam logic [APB_ADDR_W-1:0] REG_CTRL  = 5'h0C;
    localparam logic [APB_ADDR_W-1:0] REG_COUNT = 5'h10;
    localparam int CTRL_START_BIT = 0;

endpackage

`default_nettype wire

// ==== pkt_move_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pkt_move_tb;
    import pkt_move_pkg::*;

    localparam int NUM_RANDOM      = 20;
    localparam int NUM_BP          = 8;
    localparam int MAX_LEN         = 40;
    localparam int NUM_XFERS       = NUM_RANDOM + NUM_BP + 2;
    localparam int WATCHDOG_CYCLES = NUM_XFERS * MAX_LEN * 40 + 5000;

    logic                  clk;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    word_t                 pwdata;
    word_t                 prdata;
    logic                  pready;
    logic                  pslverr;
    mem_rd_req_t           rd_req;
    word_t                 rd_data = '0;
    mem_wr_req_t           wr_req;
    logic                  wr_ready = 1'b0;

    word_t       mem [65536];
    word_t       ref_mem [65536];
    addr_t       cur_src;
    addr_t       cur_dst;
    int          rd_count = 0;
    int          wr_count = 0;
    int          errors = 0;
    int          xfers = 0;
    bit          bp_mode = 1'b0;
    int          stretch = 0;
    bit          last_stall = 1'b0;
    mem_wr_req_t last_req;

    pkt_move_top u_dut (
        .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .pready, .pslverr, .rd_req, .rd_data, .wr_req, .wr_ready
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic void log_error(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        errors++;
    endfunction

    // ******************************
    // memory model and port monitors
    // ******************************
    always @(posedge clk) begin
        if (rd_req.en) begin
            rd_data <= mem[rd_req.addr];
        end
        if (wr_req.en && wr_ready) begin
            mem[wr_req.addr] <= wr_req.data;
        end
    end

    // back-pressure mode holds wr_ready low for long stretches with short high gaps
    always @(posedge clk) begin
        if (!bp_mode) begin
            wr_ready <= ($urandom % 10) < 7;
        end
        else if (stretch != 0) begin
            stretch <= stretch - 1;
        end
        else begin
            wr_ready <= !wr_ready;
            stretch  <= wr_ready ? 5 + int'($urandom % 26) : int'($urandom % 4);
        end
    end

    always @(negedge clk) begin
        if (reset) begin
            if (rd_req.en) begin
                assert (rd_req.addr == cur_src + addr_t'(rd_count))
                else log_error($sformatf("read %0d went to 0x%04h", rd_count, rd_req.addr));
                rd_count = rd_count + 1;
            end
            if (last_stall) begin
                assert (wr_req == last_req) else log_error("write request changed while stalled");
            end
            if (wr_req.en && wr_ready) begin
                assert (wr_req.addr == cur_dst + addr_t'(wr_count) &&
                        wr_req.data == ref_mem[cur_src + addr_t'(wr_count)])
                else log_error($sformatf("write %0d went to 0x%04h with 0x%08h",
                                         wr_count, wr_req.addr, wr_req.data));
                wr_count = wr_count + 1;
            end
            last_stall = wr_req.en && !wr_ready;
            last_req   = wr_req;
        end
    end

    // ******************************
    // APB tasks
    // ******************************
    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input word_t data,
                             output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        assert (pready) else log_error("pready low in access phase");
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output word_t data,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_ok(input logic [APB_ADDR_W-1:0] addr, input word_t data);
        logic err;
        apb_write(addr, data, err);
        assert (!err) else log_error($sformatf("pslverr on write to 0x%02h", addr));
    endtask

    task automatic expect_reg(input logic [APB_ADDR_W-1:0] addr, input word_t exp);
        word_t data;
        logic  err;
        apb_read(addr, data, err);
        assert (!err && data == exp)
        else log_error($sformatf("reg 0x%02h read 0x%08h, expected 0x%08h", addr, data, exp));
    endtask

    task automatic wait_idle;
        word_t data;
        logic  err;
        data = 32'h1;
        while (data[0]) begin
            apb_read(REG_CTRL, data, err);
        end
        assert (data == '0) else log_error("CTRL not idle once busy cleared");
    endtask

    task automatic check_memory;
        int i;
        int bad;
        int first;
        bad   = 0;
        first = 0;
        for (i = 0; i < 65536; i++) begin
            if (mem[i] !== ref_mem[i]) begin
                if (bad == 0) begin
                    first = i;
                end
                bad++;
            end
        end
        assert (bad == 0)
        else log_error($sformatf("%0d words differ from the model, first at 0x%04h", bad, first));
    endtask

    // ******************************
    // transfers
    // ******************************
    task automatic run_copy(input addr_t src, input addr_t dst, input len_t len, input bit retry);
        logic err;
        int   i;
        write_ok(REG_SRC, word_t'(src));
        write_ok(REG_DST, word_t'(dst));
        write_ok(REG_LEN, word_t'(len));
        cur_src  = src;
        cur_dst  = dst;
        rd_count = 0;
        wr_count = 0;
        apb_write(REG_CTRL, 32'h1, err);
        assert (!err) else log_error("start rejected while idle");
        xfers++;
        for (i = 0; i < int'(len); i++) begin
            ref_mem[dst + addr_t'(i)] = ref_mem[src + addr_t'(i)];
        end
        if (retry) begin
            apb_write(REG_CTRL, 32'h1, err);
            assert (err) else log_error("second start while busy gave no pslverr");
        end
        wait_idle();
        check_memory();
        assert (rd_count == int'(len))
        else log_error($sformatf("%0d reads issued for len %0d", rd_count, len));
        assert (wr_count == int'(len))
        else log_error($sformatf("%0d writes accepted for len %0d", wr_count, len));
        expect_reg(REG_COUNT, word_t'(xfers));
    endtask

    task automatic check_bad_addr;
        word_t data;
        logic  err;
        write_ok(REG_SRC, 32'h1357);
        write_ok(REG_DST, 32'h2468);
        write_ok(REG_LEN, 32'd7);
        apb_write(5'h14, 32'hffff_ffff, err);
        assert (err) else log_error("write to 0x14 gave no pslverr");
        apb_read(5'h1c, data, err);
        assert (err) else log_error("read of 0x1c gave no pslverr");
        apb_write(5'h06, 32'h0, err);
        assert (err) else log_error("write to 0x06 gave no pslverr");
        expect_reg(REG_SRC, 32'h1357);
        expect_reg(REG_DST, 32'h2468);
        expect_reg(REG_LEN, 32'd7);
        expect_reg(REG_COUNT, word_t'(xfers));
        expect_reg(REG_CTRL, 32'h0);
    endtask

    initial begin
        int i;
        void'($urandom(32'hc2a9));
        reset   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (i = 0; i < 65536; i++) begin
            mem[i]     = $urandom;
            ref_mem[i] = mem[i];
        end
        repeat (3) @(posedge clk);
        reset <= 1'b1;
        expect_reg(REG_COUNT, 32'h0);
        expect_reg(REG_CTRL, 32'h0);

        // sources sit in the low half and destinations in the high half
        for (i = 0; i < NUM_RANDOM; i++) begin
            run_copy(addr_t'($urandom % 32'h7f00), addr_t'(32'h8000 + $urandom % 32'h7f00),
                     len_t'(1 + $urandom % MAX_LEN), 1'b0);
        end
        run_copy(16'h0100, 16'h9000, 8'd0, 1'b0);
        run_copy(16'h0200, 16'ha000, len_t'(MAX_LEN), 1'b1);
        check_bad_addr();

        bp_mode <= 1'b1;
        for (i = 0; i < NUM_BP; i++) begin
            run_copy(addr_t'($urandom % 32'h7f00), addr_t'(32'h8000 + $urandom % 32'h7f00),
                     len_t'(1 + $urandom % MAX_LEN), 1'b0);
        end

        $display("transfers %0d, errors %0d", xfers, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end
        else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the transfers did not finish", WATCHDOG_CYCLES);
        $display("transfers %0d, errors %0d", xfers, errors);
        $display("Done: errors found");
        $finish;
    end

endmodule : pkt_move_tb

`default_nettype wire

// ==== pkt_move_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module pkt_move_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [pkt_move_pkg::APB_ADDR_W-1:0] paddr,
    input  pkt_move_pkg::word_t                 pwdata,
    output pkt_move_pkg::word_t                 prdata,
    output logic                                pready,
    output logic                                pslverr,
    output pkt_move_pkg::mem_rd_req_t           rd_req,
    input  pkt_move_pkg::word_t                 rd_data,
    output pkt_move_pkg::mem_wr_req_t           wr_req,
    input  logic                                wr_ready
);
    import pkt_move_pkg::*;

    xfer_cfg_t             cfg;
    ctrl_state_t           state;
    logic                  start;
    logic                  done;
    logic                  rd_go;
    logic                  wr_go;
    logic                  rd_done;
    logic                  wr_done;
    logic                  push;
    word_t                 push_data;
    logic                  pop;
    word_t                 front;
    logic                  empty;
    logic [FIFO_CNT_W-1:0] fifo_count;

    pkt_apb_regs u_regs (
        .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .state, .done, .start, .cfg
    );

    pkt_ctrl u_ctrl (
        .clk, .reset, .start, .rd_done, .wr_done, .rd_go, .wr_go, .done, .state
    );

    pkt_rd_engine u_rd (
        .clk, .reset, .start, .rd_go, .cfg, .rd_req, .rd_data,
        .fifo_count, .push, .push_data, .rd_done
    );

    pkt_fifo u_fifo (
        .clk, .reset, .push, .push_data, .pop, .front, .empty, .count(fifo_count)
    );

    pkt_wr_engine u_wr (
        .clk, .reset, .start, .wr_go, .cfg, .front, .empty, .pop,
        .wr_req, .wr_ready, .wr_done
    );

endmodule : pkt_move_top

`default_nettype wire

// ==== pkt_rd_engine.sv ====
`default_nettype none
`timescale 1ns/1ns

module pkt_rd_engine (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               start,
    input  logic                               rd_go,
    input  pkt_move_pkg::xfer_cfg_t            cfg,
    output pkt_move_pkg::mem_rd_req_t          rd_req,
    input  pkt_move_pkg::word_t                rd_data,
    input  logic [pkt_move_pkg::FIFO_CNT_W-1:0] fifo_count,
    output logic                               push,
    output pkt_move_pkg::word_t                push_data,
    output logic                               rd_done
);
    import pkt_move_pkg::*;

    len_t                  issued;
    len_t                  returned;
    logic                  req_en;
    addr_t                 req_addr;
    logic                  issue;
    logic [FIFO_CNT_W-1:0] committed;

    // words in the FIFO plus reads still in flight
    assign committed = fifo_count + {{(FIFO_CNT_W-1){1'b0}}, req_en}
                                  + {{(FIFO_CNT_W-1){1'b0}}, push};

    assign issue = rd_go && (issued != cfg.len) && (committed < FIFO_CNT_W'(FIFO_DEPTH));

    always_ff @(posedge clk) begin
        if (!reset) begin
            req_en <= 1'b0;
            push   <= 1'b0;
        end
        else begin
            req_en <= issue;
            push   <= req_en;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr <= cfg.src + addr_t'(issued);
        end
    end

    always_ff @(posedge clk) begin
        if (!reset || start) begin
            issued   <= '0;
            returned <= '0;
            rd_done  <= 1'b0;
        end
        else begin
            if (issue) begin
                issued <= issued + 1'b1;
            end
            if (push) begin
                returned <= returned + 1'b1;
            end
            if (rd_go && (returned == cfg.len)) begin
                rd_done <= 1'b1;
            end
        end
    end

    assign rd_req.en   = req_en;
    assign rd_req.addr = req_addr;

    // read data arrives one cycle after the request, in step with push
    assign push_data = rd_data;

endmodule : pkt_rd_engine

`default_nettype wire

// ==== pkt_wr_engine.sv ====
`default_nettype none
`timescale 1ns/1ns

module pkt_wr_engine (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  logic                      wr_go,
    input  pkt_move_pkg::xfer_cfg_t   cfg,
    input  pkt_move_pkg::word_t       front,
    input  logic                      empty,
    output logic                      pop,
    output pkt_move_pkg::mem_wr_req_t wr_req,
    input  logic                      wr_ready,
    output logic                      wr_done
);
    import pkt_move_pkg::*;

    len_t idx;
    logic wr_en;

    // front and idx only move on an accepted write, so the request holds
    assign wr_en = wr_go && !empty && (idx != cfg.len);
    assign pop   = wr_en && wr_ready;

    assign wr_req.en   = wr_en;
    assign wr_req.addr = cfg.dst + addr_t'(idx);
    assign wr_req.data = front;

    always_ff @(posedge clk) begin
        if (!reset || start) begin
            idx     <= '0;
            wr_done <= 1'b0;
        end
        else begin
            if (pop) begin
                idx <= idx + 1'b1;
            end
            if (wr_go && (idx == cfg.len)) begin
                wr_done <= 1'b1;
            end
        end
    end

endmodule : pkt_wr_engine

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module pkt_move_tb \
    -f pkt_move.f -o pkt_move_sim
./obj_dir/pkt_move_sim | tee sim.log
if grep -q "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
